//--- Makefile
VERILATOR  ?= verilator
TOP        = tb_usb_tx
FLIST      = flist.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/tx_fifo.sv
/*
 * Byte FIFO between the host and the transmitter.
 * Writes while full are dropped. rd_data is the head and is only
 * meaningful while fifo_empty is low.
 */
`timescale 1ns/1ps

module tx_fifo import usb_tx_pkg::*; (
	input  logic  clk,
	input  logic  n_rst,
	input  logic  wr_en,
	input  byte_t wr_data,
	input  logic  read_enable,
	output byte_t rd_data,
	output logic  fifo_empty,
	output logic  fifo_full
);

	byte_t mem [FIFO_DEPTH];

	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;
	logic               do_write;
	logic               do_read;

	assign do_write = wr_en && !fifo_full;
	assign do_read  = read_enable && !fifo_empty;

	assign fifo_empty = (count == '0);
	// Top count bit is set only at FIFO_DEPTH entries
	assign fifo_full  = count[FIFO_AW];

	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;

			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Controller only pops after it has seen a byte waiting
	a_no_pop_when_empty: assert property (
		@(posedge clk) disable iff (!n_rst)
		read_enable |-> !fifo_empty
	);

endmodule

//--- design/tx_line_encoder.sv
/*
 * Serializer with bit stuffing, NRZI and EOP drive on dp/dm.
 * Bits go out LSB first, one every BIT_CYCLES clocks. byte_sent pulses as the
 * last loaded bit goes onto the line, so a reload within BIT_CYCLES-1 cycles keeps pace.
 */
`timescale 1ns/1ps

module tx_line_encoder import usb_tx_pkg::*; (
	input  logic  clk,
	input  logic  n_rst,
	input  logic  load_sync,
	input  logic  load_data,
	input  logic  load_crc,
	input  logic  tx_enable,
	input  logic  create_eop,
	input  byte_t rd_data,
	input  crc_t  crc,
	output logic  byte_sent,
	output logic  tx_shift,
	output logic  bit_out,
	output logic  line_idle,
	output logic  dp,
	output logic  dm
);

	logic [BIT_TIMER_W-1:0] timer;
	logic [15:0]            shreg;
	logic [4:0]             bit_cnt;
	logic [STUFF_CNT_W-1:0] ones;
	logic [1:0]             eop_cnt;
	logic                   eop_pending;
	logic                   in_packet;

	logic tick;
	logic stuff_now;
	logic take_bit;
	logic eop_start;
	logic eop_step;

	assign tick = (timer == BIT_TIMER_W'(BIT_CYCLES - 1));

	// A stuffed zero also goes out before EOP after a final run of ones
	assign stuff_now = tick && (ones == STUFF_CNT_W'(STUFF_LEN)) &&
		((tx_enable && bit_cnt != '0) || eop_pending);
	assign take_bit  = tick && !stuff_now && tx_enable && (bit_cnt != '0);
	assign eop_start = tick && !stuff_now && eop_pending && (bit_cnt == '0) &&
		(eop_cnt == '0);
	assign eop_step  = tick && (eop_cnt != '0);

	assign tx_shift  = take_bit;
	assign bit_out   = shreg[0];
	assign byte_sent = take_bit && (bit_cnt == 5'd1);
	assign line_idle = !in_packet;

	always_ff @(posedge clk) begin
		if (load_sync)
			shreg <= {8'h00, SYNC_BYTE};
		else if (load_data)
			shreg <= {8'h00, rd_data};
		else if (load_crc)
			shreg <= crc;
		else if (take_bit)
			shreg <= {1'b0, shreg[15:1]};
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			timer       <= BIT_TIMER_W'(BIT_CYCLES - 1);
			bit_cnt     <= '0;
			ones        <= '0;
			eop_cnt     <= '0;
			eop_pending <= 1'b0;
			in_packet   <= 1'b0;
			dp          <= 1'b1;
			dm          <= 1'b0;
		end else begin
			// Parked on the last count so the first bit starts right after a load
			if (!in_packet && bit_cnt == '0)
				timer <= BIT_TIMER_W'(BIT_CYCLES - 1);
			else if (tick)
				timer <= '0;
			else
				timer <= timer + 1'b1;

			if (load_sync || load_data)
				bit_cnt <= 5'd8;
			else if (load_crc)
				bit_cnt <= 5'd16;
			else if (take_bit)
				bit_cnt <= bit_cnt - 1'b1;

			if (take_bit)
				ones <= shreg[0] ? ones + 1'b1 : '0;
			else if (stuff_now || eop_start)
				ones <= '0;

			if (create_eop)
				eop_pending <= 1'b1;
			else if (eop_start)
				eop_pending <= 1'b0;

			// Two SE0 bit times, then one J
			if (eop_start)
				eop_cnt <= 2'd3;
			else if (eop_step)
				eop_cnt <= eop_cnt - 1'b1;

			if (take_bit)
				in_packet <= 1'b1;
			else if (eop_step && eop_cnt == 2'd1)
				in_packet <= 1'b0;

			if (eop_start) begin
				dp <= 1'b0;
				dm <= 1'b0;
			end else if (eop_step && eop_cnt == 2'd2) begin
				dp <= 1'b1;
				dm <= 1'b0;
			end else if (stuff_now || (take_bit && !shreg[0])) begin
				// NRZI toggles on every zero
				dp <= ~dp;
				dm <= ~dm;
			end
		end
	end

	a_load_when_drained: assert property (
		@(posedge clk) disable iff (!n_rst)
		(load_sync || load_data || load_crc) |-> (bit_cnt == '0)
	);

	a_no_se1: assert property (
		@(posedge clk) disable iff (!n_rst)
		!(dp && dm)
	);

endmodule

//--- design/usb_crc16.sv
/*
 * Serial CRC-16 over the data stage, one bit per tx_shift.
 * crc is the inverted register, bit reversed so that crc[0] goes first.
 */
`timescale 1ns/1ps

module usb_crc16 import usb_tx_pkg::*; (
	input  logic clk,
	input  logic n_rst,
	input  logic crc_clear,
	input  logic crc_enable,
	input  logic tx_shift,
	input  logic bit_out,
	output crc_t crc
);

	crc_t crc_reg;
	logic feedback;

	assign feedback = bit_out ^ crc_reg[15];

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			crc_reg <= CRC_INIT;
		end else if (crc_clear) begin
			crc_reg <= CRC_INIT;
		end else if (crc_enable && tx_shift) begin
			if (feedback)
				crc_reg <= {crc_reg[14:0], 1'b0} ^ CRC_POLY;
			else
				crc_reg <= {crc_reg[14:0], 1'b0};
		end
	end

	// Register MSB leaves the line first
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			crc[i] = ~crc_reg[15 - i];
		end
	end

endmodule

//--- design/usb_tx_controller.sv
/*
 * Packet sequencer: SYNC, FIFO bytes, CRC, then EOP.
 * Only transmit_start begins a packet. An empty FIFO gives an empty data stage.
 */
`timescale 1ns/1ps

module usb_tx_controller import usb_tx_pkg::*; (
	input  logic clk,
	input  logic n_rst,
	input  logic transmit_start,
	input  logic fifo_empty,
	input  logic byte_sent,
	input  logic line_idle,
	output logic read_enable,
	output logic load_sync,
	output logic load_data,
	output logic load_crc,
	output logic tx_enable,
	output logic crc_enable,
	output logic crc_clear,
	output logic create_eop,
	output logic transmitting
);

	tx_state_t state;
	tx_state_t next_state;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state   = state;
		read_enable  = 1'b0;
		load_sync    = 1'b0;
		load_data    = 1'b0;
		load_crc     = 1'b0;
		tx_enable    = 1'b0;
		crc_enable   = 1'b0;
		crc_clear    = 1'b0;
		create_eop   = 1'b0;
		transmitting = 1'b1;

		case (state)
			IDLE: begin
				transmitting = 1'b0;
				crc_clear    = 1'b1;
				if (transmit_start)
					next_state = LOAD_SYNC;
			end

			LOAD_SYNC: begin
				load_sync  = 1'b1;
				next_state = TX_SYNC;
			end

			TX_SYNC: begin
				tx_enable = 1'b1;
				if (byte_sent)
					next_state = READ_FIRST;
			end

			// Also the empty check after each pop
			READ_FIRST: begin
				if (fifo_empty)
					next_state = LOAD_CRC;
				else
					next_state = LOAD;
			end

			LOAD: begin
				load_data  = 1'b1;
				next_state = TX_DATA;
			end

			TX_DATA: begin
				tx_enable  = 1'b1;
				crc_enable = 1'b1;
				if (byte_sent)
					next_state = READ;
			end

			// Drop the byte just sent
			READ: begin
				read_enable = 1'b1;
				next_state  = READ_FIRST;
			end

			LOAD_CRC: begin
				load_crc   = 1'b1;
				next_state = TX_CRC;
			end

			TX_CRC: begin
				tx_enable = 1'b1;
				if (byte_sent) begin
					create_eop = 1'b1;
					next_state = SEND_EOP;
				end
			end

			SEND_EOP: begin
				if (line_idle)
					next_state = IDLE;
			end

			default: begin
				next_state = IDLE;
			end
		endcase
	end

endmodule

//--- design/usb_tx_pkg.sv
/*
 * Shared types and constants for the full-speed packet transmitter.
 * FIFO_DEPTH must equal 2**FIFO_AW. BIT_CYCLES sets the line bit rate.
 */
package usb_tx_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] crc_t;

	// Line bit timing in clock cycles
	localparam int BIT_CYCLES = 4;
	localparam int BIT_TIMER_W = $clog2(BIT_CYCLES);

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;

	// Seven zeros then a one, LSB first
	localparam byte_t SYNC_BYTE = 8'h80;

	localparam crc_t CRC_POLY = 16'h8005;
	localparam crc_t CRC_INIT = 16'hFFFF;

	// Run of ones that forces a stuffed zero
	localparam int STUFF_LEN = 6;
	localparam int STUFF_CNT_W = $clog2(STUFF_LEN + 1);

	typedef enum logic [3:0] {
		IDLE,
		LOAD_SYNC,
		TX_SYNC,
		READ_FIRST,
		LOAD,
		TX_DATA,
		READ,
		LOAD_CRC,
		TX_CRC,
		SEND_EOP
	} tx_state_t;

endpackage

//--- design/usb_tx_top.sv
/*
 * Full-speed style packet transmitter. One byte per cycle on wr_en,
 * a pulse on transmit_start sends the FIFO contents as one packet.
 */
`timescale 1ns/1ps

module usb_tx_top import usb_tx_pkg::*; (
	input  logic  clk,
	input  logic  n_rst,
	input  logic  wr_en,
	input  byte_t wr_data,
	input  logic  transmit_start,
	output logic  fifo_full,
	output logic  transmitting,
	output logic  dp,
	output logic  dm
);

	byte_t rd_data;
	crc_t  crc;
	logic  fifo_empty;
	logic  read_enable;
	logic  load_sync;
	logic  load_data;
	logic  load_crc;
	logic  tx_enable;
	logic  crc_enable;
	logic  crc_clear;
	logic  create_eop;
	logic  byte_sent;
	logic  line_idle;
	logic  tx_shift;
	logic  bit_out;

	tx_fifo u_fifo (
		.clk         (clk),
		.n_rst       (n_rst),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.read_enable (read_enable),
		.rd_data     (rd_data),
		.fifo_empty  (fifo_empty),
		.fifo_full   (fifo_full)
	);

	usb_tx_controller u_ctrl (
		.clk            (clk),
		.n_rst          (n_rst),
		.transmit_start (transmit_start),
		.fifo_empty     (fifo_empty),
		.byte_sent      (byte_sent),
		.line_idle      (line_idle),
		.read_enable    (read_enable),
		.load_sync      (load_sync),
		.load_data      (load_data),
		.load_crc       (load_crc),
		.tx_enable      (tx_enable),
		.crc_enable     (crc_enable),
		.crc_clear      (crc_clear),
		.create_eop     (create_eop),
		.transmitting   (transmitting)
	);

	usb_crc16 u_crc (
		.clk        (clk),
		.n_rst      (n_rst),
		.crc_clear  (crc_clear),
		.crc_enable (crc_enable),
		.tx_shift   (tx_shift),
		.bit_out    (bit_out),
		.crc        (crc)
	);

	tx_line_encoder u_enc (
		.clk        (clk),
		.n_rst      (n_rst),
		.load_sync  (load_sync),
		.load_data  (load_data),
		.load_crc   (load_crc),
		.tx_enable  (tx_enable),
		.create_eop (create_eop),
		.rd_data    (rd_data),
		.crc        (crc),
		.byte_sent  (byte_sent),
		.tx_shift   (tx_shift),
		.bit_out    (bit_out),
		.line_idle  (line_idle),
		.dp         (dp),
		.dm         (dm)
	);

endmodule

//--- flist.f
design/usb_tx_pkg.sv
design/tx_fifo.sv
design/usb_crc16.sv
design/tx_line_encoder.sv
design/usb_tx_controller.sv
design/usb_tx_top.sv
testbench/tb_usb_tx.sv

//--- testbench/tb_usb_tx.sv
/*
 * Testbench for usb_tx_top. A line monitor decodes NRZI, strips stuffed bits
 * and checks the stream against a byte queue model with its own CRC-16.
 * Watchdog limit scales with the packet count and the longest packet.
 */
`timescale 1ns/1ps

module tb_usb_tx import usb_tx_pkg::*; ();

	localparam int CLK_PERIOD_NS  = 4;
	localparam int RESET_CYCLES   = 8;
	localparam int RANDOM_PACKETS = 20;
	localparam int NUM_PACKETS    = RANDOM_PACKETS + 8;
	// Cycles from the edge that sees transmit_start until the line leaves J
	localparam int START_CYCLES   = 3;
	// Worst case line bits including stuffed zeros and EOP
	localparam int MAX_PKT_BITS   = (8 * FIFO_DEPTH + 24) * (STUFF_LEN + 1) / STUFF_LEN + 4;
	localparam int WATCHDOG_NS    = (NUM_PACKETS * MAX_PKT_BITS * BIT_CYCLES * 2
		+ RESET_CYCLES * 4) * CLK_PERIOD_NS;

	logic  clk;
	logic  n_rst;
	logic  wr_en;
	byte_t wr_data;
	logic  transmit_start;
	logic  fifo_full;
	logic  transmitting;
	logic  dp;
	logic  dm;

	byte_t model_q[$];
	bit    rx_bits[$];
	crc_t  last_rx_crc;
	int    stuffed_bits;
	int    errors;
	int    tests_run;
	int    tests_failed;

	usb_tx_top uut (
		.clk            (clk),
		.n_rst          (n_rst),
		.wr_en          (wr_en),
		.wr_data        (wr_data),
		.transmit_start (transmit_start),
		.fifo_full      (fifo_full),
		.transmitting   (transmitting),
		.dp             (dp),
		.dm             (dm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all tests finished");
		$display("sim failed");
		$finish;
	end

	task automatic check_value(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			$display("ERROR %s: expected %0h, got %0h", sig, exp, got);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - errors_before);
		end
	endtask

	function automatic byte_t random_byte();
		return byte_t'($urandom());
	endfunction

	// USB CRC-16 over the queued bytes, LSB first, result in line order
	function automatic crc_t expected_crc();
		crc_t r;
		crc_t res;
		logic fb;
		r = CRC_INIT;
		foreach (model_q[i]) begin
			for (int b = 0; b < 8; b++) begin
				fb = model_q[i][b] ^ r[15];
				r = {r[14:0], 1'b0};
				if (fb)
					r = r ^ CRC_POLY;
			end
		end
		for (int k = 0; k < 16; k++)
			res[k] = ~r[15 - k];
		return res;
	endfunction

	function automatic byte_t rx_byte(input int start);
		byte_t b;
		for (int j = 0; j < 8; j++)
			b[j] = rx_bits[start + j];
		return b;
	endfunction

	task automatic write_byte(input byte_t b);
		@(negedge clk);
		wr_en = 1'b1;
		wr_data = b;
		// FIFO drops writes once full
		if (model_q.size() < FIFO_DEPTH)
			model_q.push_back(b);
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic pulse_start();
		@(negedge clk);
		transmit_start = 1'b1;
		@(negedge clk);
		transmit_start = 1'b0;
	endtask

	// Samples mid-bit, decodes NRZI, drops stuffed zeros, then checks EOP
	task automatic receive_packet();
		int  wait_cnt;
		int  ones_run;
		int  se0_cnt;
		int  nbits;
		bit  prev_dp;
		bit  raw;
		bit  done;
		rx_bits.delete();
		wait_cnt = 0;
		// Entered half a cycle after the edge that saw transmit_start
		while (dp && !dm && wait_cnt < START_CYCLES - 1) begin
			@(negedge clk);
			wait_cnt++;
		end
		assert (!(dp && !dm)) else begin
			$display("line did not leave idle J within %0d cycles of transmit_start",
				START_CYCLES);
			errors++;
		end
		if (dp && !dm)
			return;

		repeat (BIT_CYCLES / 2) @(negedge clk);
		prev_dp = 1'b1;
		ones_run = 0;
		se0_cnt = 0;
		nbits = 0;
		done = 1'b0;
		while (!done) begin
			check_value("transmitting", 32'(transmitting), 32'd1);
			if (!dp && !dm) begin
				se0_cnt++;
			end else if (se0_cnt > 0) begin
				assert (dp && !dm) else begin
					$display("line not J after the SE0 of the end of packet");
					errors++;
				end
				done = 1'b1;
			end else begin
				raw = (dp == prev_dp);
				prev_dp = dp;
				if (ones_run == STUFF_LEN) begin
					assert (!raw) else begin
						$display("no transition for more than %0d bit times", STUFF_LEN);
						errors++;
					end
					if (!raw)
						stuffed_bits++;
					ones_run = 0;
				end else begin
					rx_bits.push_back(raw);
					ones_run = raw ? ones_run + 1 : 0;
				end
			end
			nbits++;
			if (nbits > MAX_PKT_BITS && !done) begin
				$display("packet ran longer than %0d bit times", MAX_PKT_BITS);
				errors++;
				done = 1'b1;
			end
			if (!done)
				repeat (BIT_CYCLES) @(negedge clk);
		end
		check_value("se0 bit times", 32'(se0_cnt), 32'd2);

		wait_cnt = 0;
		while (transmitting && wait_cnt < 2 * BIT_CYCLES) begin
			@(negedge clk);
			wait_cnt++;
		end
		assert (!transmitting) else begin
			$display("transmitting did not fall after the end of packet");
			errors++;
		end
	endtask

	task automatic check_packet();
		int   n;
		crc_t exp_crc;
		n = model_q.size();
		exp_crc = expected_crc();
		check_value("rx bit count", 32'(rx_bits.size()), 32'(8 * n + 24));
		if (rx_bits.size() != 8 * n + 24)
			return;
		check_value("rx sync", 32'(rx_byte(0)), 32'(SYNC_BYTE));
		for (int i = 0; i < n; i++)
			check_value($sformatf("rx byte %0d", i), 32'(rx_byte(8 + 8 * i)), 32'(model_q[i]));
		for (int k = 0; k < 16; k++)
			last_rx_crc[k] = rx_bits[8 * n + 8 + k];
		check_value("rx crc", 32'(last_rx_crc), 32'(exp_crc));
	endtask

	task automatic send_packet(input bit mid_start);
		pulse_start();
		fork
			receive_packet();
			begin
				if (mid_start) begin
					repeat (10 * BIT_CYCLES) @(negedge clk);
					pulse_start();
				end
			end
		join
		check_packet();
		model_q.delete();
	endtask

	task automatic check_line_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_value("dp", 32'(dp), 32'd1);
			check_value("dm", 32'(dm), 32'd0);
			check_value("transmitting", 32'(transmitting), 32'd0);
		end
	endtask

	initial begin
		int n;
		int errors_before;
		void'($urandom(32'h4c80_b58a));
		n_rst = 1'b0;
		wr_en = 1'b0;
		wr_data = '0;
		transmit_start = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		stuffed_bits = 0;

		errors_before = errors;
		repeat (RESET_CYCLES) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		check_value("dp", 32'(dp), 32'd1);
		check_value("dm", 32'(dm), 32'd0);
		check_value("transmitting", 32'(transmitting), 32'd0);
		check_value("fifo_full", 32'(fifo_full), 32'd0);
		finish_test("reset state", errors_before);

		errors_before = errors;
		for (int p = 0; p < RANDOM_PACKETS; p++) begin
			n = int'($urandom_range(FIFO_DEPTH, 0));
			for (int i = 0; i < n; i++)
				write_byte(random_byte());
			send_packet(1'b0);
		end
		finish_test("random packets", errors_before);

		errors_before = errors;
		stuffed_bits = 0;
		for (int p = 0; p < 3; p++) begin
			n = (p == 0) ? 1 : (p == 1) ? FIFO_DEPTH / 2 : FIFO_DEPTH;
			for (int i = 0; i < n; i++)
				write_byte(8'hFF);
			send_packet(1'b0);
		end
		assert (stuffed_bits > 0) else begin
			$display("no stuffed bits seen in the all-ones packets");
			errors++;
		end
		finish_test("bit stuffing", errors_before);

		errors_before = errors;
		for (int p = 0; p < 2; p++) begin
			n = int'($urandom_range(FIFO_DEPTH, 1));
			for (int i = 0; i < n; i++)
				write_byte(random_byte());
			send_packet(1'b0);
			check_line_quiet(2 * BIT_CYCLES);
		end
		finish_test("end of packet", errors_before);

		errors_before = errors;
		for (int i = 0; i < FIFO_DEPTH + 3; i++)
			write_byte(random_byte());
		check_value("fifo_full", 32'(fifo_full), 32'd1);
		send_packet(1'b0);
		check_value("fifo_full", 32'(fifo_full), 32'd0);
		finish_test("fifo full", errors_before);

		errors_before = errors;
		for (int i = 0; i < 4; i++)
			write_byte(random_byte());
		send_packet(1'b1);
		check_line_quiet(8 * BIT_CYCLES);
		finish_test("start during packet", errors_before);

		errors_before = errors;
		send_packet(1'b0);
		check_value("empty packet crc", 32'(last_rx_crc), 32'h0000);
		finish_test("empty packet", errors_before);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
